// File: Makefile
TOP = vdp_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: bench/vdp_tb.sv
// VDP color output path testbench
// Directed tests for raster timing, host readback, palette writes,
// layer priority, alpha-over and blanking

`timescale 1ns/1ps
`default_nettype none

module vdp_tb;
    import vdp_pkg::*;

    localparam int unsigned LINE_CYCLES = 800;
    localparam int unsigned FRAME_LINES = 524;
    localparam int unsigned FRAME_CYCLES = LINE_CYCLES * FRAME_LINES;
    localparam int unsigned WATCHDOG_CYCLES = 3 * FRAME_CYCLES + 20000;
    localparam int unsigned RANDOM_SEED = 32'h5b6;

    logic clk;
    logic reset;
    host_addr_t host_address;
    host_data_t host_write_data;
    logic host_write_en;
    logic host_read_en;
    host_data_t host_read_data;
    logic host_ready;
    pixel_t layer0_pixel;
    pixel_t layer1_pixel;
    channel_t r;
    channel_t g;
    channel_t b;
    logic vga_hsync;
    logic vga_vsync;
    logic active_display;
    logic line_ended;
    logic frame_ended;

    // Cycles since reset release, cycle 0 is the first one
    int unsigned cycle;
    palette_entry_t palette_model [256];

    vdp_top vdp_top_i (
        .clk(clk),
        .reset(reset),
        .host_address(host_address),
        .host_write_data(host_write_data),
        .host_write_en(host_write_en),
        .host_read_en(host_read_en),
        .host_read_data(host_read_data),
        .host_ready(host_ready),
        .layer0_pixel(layer0_pixel),
        .layer1_pixel(layer1_pixel),
        .r(r),
        .g(g),
        .b(b),
        .vga_hsync(vga_hsync),
        .vga_vsync(vga_vsync),
        .active_display(active_display),
        .line_ended(line_ended),
        .frame_ended(frame_ended)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Errors found");
        $fatal(1, "timeout, the tests did not finish in time");
    end

    function automatic int unsigned line_position(input int unsigned n);
        return n % LINE_CYCLES;
    endfunction

    function automatic int unsigned line_number(input int unsigned n);
        return (n / LINE_CYCLES) % FRAME_LINES;
    endfunction

    function automatic logic [11:0] entry_rgb(input palette_entry_t entry);
        return entry[11:0];
    endfunction

    // Per channel mean, rounded down
    function automatic logic [11:0] average_rgb(input palette_entry_t source,
                                                input palette_entry_t dest);
        logic [11:0] result;
        for (int c = 0; c < 3; c++) begin
            result[c*4 +: 4] = 4'((5'(source[c*4 +: 4]) + 5'(dest[c*4 +: 4])) >> 1);
        end
        return result;
    endfunction

    task automatic compare_value(input string what, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error at time %0t (cycle %0d): %s, got 0x%0h, expected 0x%0h",
                $time, cycle, what, actual, expected);
            $display("Errors found");
            $fatal(1, "value mismatch");
        end
    endtask

    // Inputs change 1 ns after the edge, outputs are stable there too
    task automatic next_cycle;
        @(posedge clk);
        #1;
        cycle++;
    endtask

    task automatic host_write(input logic [1:0] select, input host_data_t data);
        host_address = 16'(select);
        host_write_data = data;
        host_write_en = 1'b1;
        next_cycle();
        host_write_en = 1'b0;
    endtask

    task automatic host_read(input logic [1:0] select, output host_data_t data,
                             output int unsigned sample_cycle);
        host_address = 16'(select);
        host_read_en = 1'b1;
        sample_cycle = cycle;
        next_cycle();
        host_read_en = 1'b0;
        compare_value("host_ready after read", 32'(host_ready), 32'd1);
        data = host_read_data;
        next_cycle();
        compare_value("host_ready held too long", 32'(host_ready), 32'd0);
    endtask

    // Step until the next run cycles all fall in the active window
    task automatic find_active_run(input int unsigned run);
        while (cycle == 0 || line_number(cycle) >= 480 || line_position(cycle) + run > 640) begin
            next_cycle();
        end
    endtask

    task automatic show_pixel(input pixel_t l0, input pixel_t l1,
                              input logic [11:0] expected, input string what);
        find_active_run(1);
        layer0_pixel = l0;
        layer1_pixel = l1;
        repeat (3) next_cycle();
        compare_value(what, 32'({r, g, b}), 32'(expected));
    endtask

    task automatic timing_sweep;
        int unsigned x;
        int unsigned y;
        for (int unsigned n = 0; n < FRAME_CYCLES + 2 * LINE_CYCLES; n++) begin
            x = line_position(cycle);
            y = line_number(cycle);
            compare_value("hsync", 32'(vga_hsync), 32'(!(x >= 656 && x <= 751)));
            compare_value("vsync", 32'(vga_vsync), 32'(!(y >= 491 && y <= 492)));
            // Low in the first cycle after reset
            compare_value("active_display", 32'(active_display),
                32'(cycle != 0 && x < 640 && y < 480));
            compare_value("line_ended", 32'(line_ended), 32'(x == 799));
            compare_value("frame_ended", 32'(frame_ended), 32'(x == 799 && y == 523));
            compare_value("host_ready while idle", 32'(host_ready), 32'd0);
            next_cycle();
        end
    endtask

    task automatic raster_readback;
        host_data_t value;
        int unsigned sampled;
        host_read(RD_RASTER_X, value, sampled);
        compare_value("raster_x readback", 32'(value), 32'(line_position(sampled)));
        host_read(RD_RASTER_Y, value, sampled);
        compare_value("raster_y readback", 32'(value), 32'(line_number(sampled)));
        // Upper data bits are dropped
        host_write(REG_LAYER_ENABLE, 16'hfff2);
        host_read(RD_LAYER_ENABLE, value, sampled);
        compare_value("layer enable readback", 32'(value), 32'd2);
        host_write(REG_ALPHA_OVER, 16'h0001);
        host_read(RD_ALPHA_OVER, value, sampled);
        compare_value("alpha-over readback", 32'(value), 32'd1);
        host_write(REG_ALPHA_OVER, 16'h0000);
        host_write(REG_LAYER_ENABLE, 16'h0000);
    endtask

    task automatic palette_autoincrement;
        palette_addr_t written [8];
        host_data_t value;
        host_write(REG_PALETTE_ADDRESS, 16'd254);
        for (int i = 0; i < 8; i++) begin
            written[i] = 8'(254 + i);
            value = 16'($urandom);
            palette_model[written[i]] = value;
            host_write(REG_PALETTE_DATA, value);
        end
        host_write(REG_LAYER_ENABLE, 16'h0001);
        // Layer 1 is disabled, so this opaque index stays hidden
        layer1_pixel = 8'h02;
        find_active_run(8);
        // Pixels overlap in the pipeline, results trail by 3 cycles
        for (int i = 0; i < 11; i++) begin
            layer0_pixel = (i < 8) ? written[i] : 8'h00;
            if (i >= 3) begin
                compare_value($sformatf("palette entry %0d", written[i-3]), 32'({r, g, b}),
                    32'(entry_rgb(palette_model[written[i-3]])));
            end
            next_cycle();
        end
    endtask

    task automatic priority_cases;
        host_write(REG_ALPHA_OVER, 16'h0000);
        host_write(REG_LAYER_ENABLE, 16'h0003);
        show_pixel(8'h01, 8'h02, entry_rgb(palette_model[8'h02]), "opaque front layer");
        show_pixel(8'h01, 8'h30, entry_rgb(palette_model[8'h01]), "transparent front layer");
        show_pixel(8'h40, 8'h30, entry_rgb(palette_model[8'h00]), "both layers transparent");
        host_write(REG_LAYER_ENABLE, 16'h0001);
        show_pixel(8'h01, 8'h02, entry_rgb(palette_model[8'h01]), "front layer disabled");
        host_write(REG_LAYER_ENABLE, 16'h0002);
        show_pixel(8'h01, 8'h02, entry_rgb(palette_model[8'h02]), "back layer disabled");
        show_pixel(8'h01, 8'h30, entry_rgb(palette_model[8'h00]), "back hidden, front clear");
    endtask

    task automatic alpha_over_mix;
        host_write(REG_LAYER_ENABLE, 16'h0003);
        host_write(REG_ALPHA_OVER, 16'h0002);
        show_pixel(8'h01, 8'h02, average_rgb(palette_model[8'h02], palette_model[8'h01]),
            "alpha over opaque back layer");
        show_pixel(8'h50, 8'h02, average_rgb(palette_model[8'h02], palette_model[8'h00]),
            "alpha over entry 0");
        // Back layer as the alpha source with nothing under it
        host_write(REG_ALPHA_OVER, 16'h0001);
        show_pixel(8'h01, 8'h30, average_rgb(palette_model[8'h01], palette_model[8'h00]),
            "alpha back layer alone");
        host_write(REG_ALPHA_OVER, 16'h0000);
    endtask

    task automatic blanking_window;
        host_write(REG_LAYER_ENABLE, 16'h0003);
        layer0_pixel = 8'h01;
        layer1_pixel = 8'h02;
        next_cycle();
        while (!(line_position(cycle) == 640 && line_number(cycle) < 480)) begin
            next_cycle();
        end
        compare_value("active_display at end of line", 32'(active_display), 32'd0);
        repeat (2) next_cycle();
        compare_value("last active pixel", 32'({r, g, b}),
            32'(entry_rgb(palette_model[8'h02])));
        next_cycle();
        for (int i = 0; i < 160; i++) begin
            compare_value("rgb during blanking", 32'({r, g, b}), 32'd0);
            next_cycle();
        end
    endtask

    initial begin
        reset = 1'b1;
        host_address = '0;
        host_write_data = '0;
        host_write_en = 1'b0;
        host_read_en = 1'b0;
        layer0_pixel = '0;
        layer1_pixel = '0;
        cycle = 0;
        void'($urandom(RANDOM_SEED));

        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        timing_sweep();
        raster_readback();
        palette_autoincrement();
        priority_cases();
        alpha_over_mix();
        blanking_window();

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/blender.sv
// Blender
// Alpha-over mix of source and destination colors, blanking and the
// registered RGB output

`timescale 1ns/1ps
`default_nettype none

module blender (
    input  wire clk,
    input  wire reset,

    input  wire vdp_pkg::palette_entry_t source_color,
    input  wire vdp_pkg::palette_entry_t dest_color,
    input  wire source_is_alpha,
    input  wire active,

    output vdp_pkg::channel_t r,
    output vdp_pkg::channel_t g,
    output vdp_pkg::channel_t b
);
    import vdp_pkg::*;

    logic alpha_aligned;
    logic active_aligned;
    channel_t mix_r;
    channel_t mix_g;
    channel_t mix_b;

    // Average rounded down, or the destination alone
    function automatic channel_t mix_channel(channel_t source, channel_t dest, logic alpha);
        logic [4:0] sum;
        sum = {1'b0, source} + {1'b0, dest};
        return alpha ? sum[4:1] : dest;
    endfunction

    // Flags arrive a cycle ahead of the palette colors
    always_ff @(posedge clk) begin
        if (reset) begin
            alpha_aligned <= 1'b0;
            active_aligned <= 1'b0;
        end else begin
            alpha_aligned <= source_is_alpha;
            active_aligned <= active;
        end
    end

    assign mix_r = mix_channel(source_color[11:8], dest_color[11:8], alpha_aligned);
    assign mix_g = mix_channel(source_color[7:4], dest_color[7:4], alpha_aligned);
    assign mix_b = mix_channel(source_color[3:0], dest_color[3:0], alpha_aligned);

    always_ff @(posedge clk) begin
        if (reset || !active_aligned) begin
            r <= '0;
            g <= '0;
            b <= '0;
        end else begin
            r <= mix_r;
            g <= mix_g;
            b <= mix_b;
        end
    end

endmodule

`default_nettype wire

// File: rtl/host_regs.sv
// Host register block
// Decodes single-cycle host writes into the layer controls and the
// auto-incrementing palette write port, and returns readback data
// one cycle after a read request

`timescale 1ns/1ps
`default_nettype none

module host_regs (
    input  wire clk,
    input  wire reset,

    input  wire vdp_pkg::host_addr_t host_address,
    input  wire vdp_pkg::host_data_t host_write_data,
    input  wire host_write_en,
    input  wire host_read_en,

    input  wire video_timing_pkg::raster_x_t raster_x,
    input  wire video_timing_pkg::raster_y_t raster_y,

    output vdp_pkg::host_data_t host_read_data,
    output logic host_ready,

    output logic palette_write_en,
    output vdp_pkg::palette_addr_t palette_write_address,
    output vdp_pkg::palette_entry_t palette_write_data,

    output vdp_pkg::layer_mask_t layer_enable,
    output vdp_pkg::layer_mask_t alpha_over
);
    import vdp_pkg::*;

    logic [1:0] reg_select;

    assign reg_select = host_address[1:0];

    // Data writes go straight to the palette at the current address
    assign palette_write_en = host_write_en && reg_select == REG_PALETTE_DATA;
    assign palette_write_data = palette_entry_t'(host_write_data);

    always_ff @(posedge clk) begin
        if (reset) begin
            palette_write_address <= '0;
            layer_enable <= '0;
            alpha_over <= '0;
        end else if (host_write_en) begin
            case (reg_select)
                REG_PALETTE_ADDRESS: palette_write_address <= host_write_data[7:0];
                // Wraps 255 to 0
                REG_PALETTE_DATA: palette_write_address <= palette_write_address + 1'b1;
                REG_LAYER_ENABLE: layer_enable <= host_write_data[1:0];
                REG_ALPHA_OVER: alpha_over <= host_write_data[1:0];
            endcase
        end
    end

    // Ready follows the request by one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            host_ready <= 1'b0;
        end else begin
            host_ready <= host_read_en;
        end
    end

    always_ff @(posedge clk) begin
        if (host_read_en) begin
            case (reg_select)
                RD_RASTER_X: host_read_data <= host_data_t'(raster_x);
                RD_RASTER_Y: host_read_data <= host_data_t'(raster_y);
                RD_LAYER_ENABLE: host_read_data <= host_data_t'(layer_enable);
                RD_ALPHA_OVER: host_read_data <= host_data_t'(alpha_over);
            endcase
        end
    end

    // Host never reads and writes in the same cycle
    assert property (@(posedge clk) disable iff (reset)
        !(host_write_en && host_read_en))
        else $error("host read and write in the same cycle");

    // One read in flight at a time
    assert property (@(posedge clk) disable iff (reset)
        host_read_en |=> !host_read_en)
        else $error("host read issued while another is outstanding");

endmodule

`default_nettype wire

// File: rtl/layer_priority.sv
// Layer priority stage
// Picks the destination and source palette indices from the two
// layer pixels and registers them with the active flag

`timescale 1ns/1ps
`default_nettype none

module layer_priority (
    input  wire clk,
    input  wire reset,

    input  wire vdp_pkg::pixel_t layer0_pixel,
    input  wire vdp_pkg::pixel_t layer1_pixel,
    input  wire active_display,
    input  wire vdp_pkg::layer_mask_t layer_enable,
    input  wire vdp_pkg::layer_mask_t alpha_over,

    output vdp_pkg::palette_addr_t dest_index,
    output vdp_pkg::palette_addr_t source_index,
    output logic source_is_alpha,
    output logic active_delayed
);
    import vdp_pkg::*;

    pixel_t layer_pixel [LAYER_COUNT];
    layer_mask_t visible;
    palette_addr_t dest_next;
    palette_addr_t source_next;
    logic source_alpha_next;

    assign layer_pixel[0] = layer0_pixel;
    assign layer_pixel[1] = layer1_pixel;

    // Back to front, so later layers override earlier ones
    always_comb begin
        dest_next = '0;
        source_next = '0;
        source_alpha_next = 1'b0;
        for (int i = 0; i < LAYER_COUNT; i++) begin
            visible[i] = layer_enable[i] && layer_pixel[i][3:0] != 4'h0;
            if (visible[i]) begin
                source_next = layer_pixel[i];
                source_alpha_next = alpha_over[i];
                // Alpha layers never become the destination
                if (!alpha_over[i]) begin
                    dest_next = layer_pixel[i];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active_delayed <= 1'b0;
            source_is_alpha <= 1'b0;
        end else begin
            active_delayed <= active_display;
            source_is_alpha <= source_alpha_next;
        end
    end

    always_ff @(posedge clk) begin
        dest_index <= dest_next;
        source_index <= source_next;
    end

endmodule

`default_nettype wire

// File: rtl/palette_ram.sv
// Palette RAM
// 256 x 16 color table, one write port and two registered read
// ports for the destination and source lookups

`timescale 1ns/1ps
`default_nettype none

module palette_ram (
    input  wire clk,

    input  wire write_en,
    input  wire vdp_pkg::palette_addr_t write_address,
    input  wire vdp_pkg::palette_entry_t write_data,

    input  wire vdp_pkg::palette_addr_t dest_index,
    input  wire vdp_pkg::palette_addr_t source_index,

    output vdp_pkg::palette_entry_t dest_color,
    output vdp_pkg::palette_entry_t source_color
);
    import vdp_pkg::*;

    palette_entry_t entries [PALETTE_SIZE];

    // Reads in the write cycle still see the old entry
    always_ff @(posedge clk) begin
        if (write_en) begin
            entries[write_address] <= write_data;
        end
        dest_color <= entries[dest_index];
        source_color <= entries[source_index];
    end

endmodule

`default_nettype wire

// File: rtl/vdp_pkg.sv
// VDP package
// Host register map, pixel, palette and color types shared by the
// color output path

`default_nettype none

package vdp_pkg;

    typedef logic [15:0] host_addr_t;
    typedef logic [15:0] host_data_t;

    // Write register map, low two address bits
    localparam logic [1:0] REG_PALETTE_ADDRESS = 2'd0;
    localparam logic [1:0] REG_PALETTE_DATA = 2'd1;
    localparam logic [1:0] REG_LAYER_ENABLE = 2'd2;
    localparam logic [1:0] REG_ALPHA_OVER = 2'd3;

    // Readback map
    localparam logic [1:0] RD_RASTER_X = 2'd0;
    localparam logic [1:0] RD_RASTER_Y = 2'd1;
    localparam logic [1:0] RD_LAYER_ENABLE = 2'd2;
    localparam logic [1:0] RD_ALPHA_OVER = 2'd3;

    // Upper nibble palette number, lower nibble color (0 is transparent)
    typedef logic [7:0] pixel_t;

    typedef logic [7:0] palette_addr_t;
    localparam int PALETTE_SIZE = 256;

    // Red 11..8, green 7..4, blue 3..0
    typedef logic [15:0] palette_entry_t;
    typedef logic [3:0] channel_t;

    // Bit 1 is the front layer
    localparam int LAYER_COUNT = 2;
    typedef logic [LAYER_COUNT-1:0] layer_mask_t;

    // Layer pixel in to RGB out
    localparam int PIXEL_LATENCY = 3;

endpackage

`default_nettype wire

// File: rtl/vdp_top.sv
// VDP color output path, top level
// VGA timing, host registers, layer priority, dual-read palette
// and blender

`timescale 1ns/1ps
`default_nettype none

module vdp_top (
    input  wire clk,
    input  wire reset,

    input  wire vdp_pkg::host_addr_t host_address,
    input  wire vdp_pkg::host_data_t host_write_data,
    input  wire host_write_en,
    input  wire host_read_en,
    output wire vdp_pkg::host_data_t host_read_data,
    output wire host_ready,

    input  wire vdp_pkg::pixel_t layer0_pixel,
    input  wire vdp_pkg::pixel_t layer1_pixel,

    output wire vdp_pkg::channel_t r,
    output wire vdp_pkg::channel_t g,
    output wire vdp_pkg::channel_t b,
    output wire vga_hsync,
    output wire vga_vsync,
    output wire active_display,
    output wire line_ended,
    output wire frame_ended
);
    import vdp_pkg::*;
    import video_timing_pkg::*;

    wire raster_x_t raster_x;
    wire raster_y_t raster_y;

    wire palette_write_en;
    wire palette_addr_t palette_write_address;
    wire palette_entry_t palette_write_data;
    wire layer_mask_t layer_enable;
    wire layer_mask_t alpha_over;

    wire palette_addr_t dest_index;
    wire palette_addr_t source_index;
    wire source_is_alpha;
    wire active_delayed;

    wire palette_entry_t dest_color;
    wire palette_entry_t source_color;

    vga_timing vga_timing_i (
        .clk(clk),
        .reset(reset),
        .raster_x(raster_x),
        .raster_y(raster_y),
        .hsync(vga_hsync),
        .vsync(vga_vsync),
        .active_display(active_display),
        .line_ended(line_ended),
        .frame_ended(frame_ended)
    );

    host_regs host_regs_i (
        .clk(clk),
        .reset(reset),
        .host_address(host_address),
        .host_write_data(host_write_data),
        .host_write_en(host_write_en),
        .host_read_en(host_read_en),
        .raster_x(raster_x),
        .raster_y(raster_y),
        .host_read_data(host_read_data),
        .host_ready(host_ready),
        .palette_write_en(palette_write_en),
        .palette_write_address(palette_write_address),
        .palette_write_data(palette_write_data),
        .layer_enable(layer_enable),
        .alpha_over(alpha_over)
    );

    // Stage 1
    layer_priority layer_priority_i (
        .clk(clk),
        .reset(reset),
        .layer0_pixel(layer0_pixel),
        .layer1_pixel(layer1_pixel),
        .active_display(active_display),
        .layer_enable(layer_enable),
        .alpha_over(alpha_over),
        .dest_index(dest_index),
        .source_index(source_index),
        .source_is_alpha(source_is_alpha),
        .active_delayed(active_delayed)
    );

    // Stage 2
    palette_ram palette_ram_i (
        .clk(clk),
        .write_en(palette_write_en),
        .write_address(palette_write_address),
        .write_data(palette_write_data),
        .dest_index(dest_index),
        .source_index(source_index),
        .dest_color(dest_color),
        .source_color(source_color)
    );

    // Stage 3
    blender blender_i (
        .clk(clk),
        .reset(reset),
        .source_color(source_color),
        .dest_color(dest_color),
        .source_is_alpha(source_is_alpha),
        .active(active_delayed),
        .r(r),
        .g(g),
        .b(b)
    );

endmodule

`default_nettype wire

// File: rtl/vga_timing.sv
// VGA timing generator
// Raster counters with registered syncs, active window and
// end of line / end of frame strobes

`timescale 1ns/1ps
`default_nettype none

module vga_timing (
    input  wire clk,
    input  wire reset,

    output video_timing_pkg::raster_x_t raster_x,
    output video_timing_pkg::raster_y_t raster_y,

    output logic hsync,
    output logic vsync,
    output logic active_display,
    output logic line_ended,
    output logic frame_ended
);
    import video_timing_pkg::*;

    raster_x_t next_x;
    raster_y_t next_y;

    always_comb begin
        next_x = raster_x + 1'b1;
        next_y = raster_y;
        if (raster_x == raster_x_t'(H_TOTAL - 1)) begin
            next_x = '0;
            next_y = (raster_y == raster_y_t'(V_TOTAL - 1)) ? '0 : raster_y + 1'b1;
        end
    end

    // Flags come from the next position so they line up with the counters
    always_ff @(posedge clk) begin
        if (reset) begin
            raster_x <= '0;
            raster_y <= '0;
            hsync <= 1'b1;
            vsync <= 1'b1;
            active_display <= 1'b0;
            line_ended <= 1'b0;
            frame_ended <= 1'b0;
        end else begin
            raster_x <= next_x;
            raster_y <= next_y;
            hsync <= !(next_x >= raster_x_t'(H_SYNC_START) && next_x < raster_x_t'(H_SYNC_END));
            vsync <= !(next_y >= raster_y_t'(V_SYNC_START) && next_y < raster_y_t'(V_SYNC_END));
            active_display <= next_x < raster_x_t'(H_ACTIVE) && next_y < raster_y_t'(V_ACTIVE);
            line_ended <= next_x == raster_x_t'(H_TOTAL - 1);
            frame_ended <= next_x == raster_x_t'(H_TOTAL - 1)
                && next_y == raster_y_t'(V_TOTAL - 1);
        end
    end

    // Horizontal count stays inside the line
    assert property (@(posedge clk) disable iff (reset)
        raster_x <= raster_x_t'(H_TOTAL - 1))
        else $error("raster_x past end of line");

endmodule

`default_nettype wire

// File: rtl/video_timing_pkg.sv
// Video timing package
// 640x480 at 60 Hz porch and sync widths, derived totals and the
// raster coordinate types

`default_nettype none

package video_timing_pkg;

    // Horizontal, in pixel clocks
    localparam int H_ACTIVE = 640;
    localparam int H_FRONTPORCH = 16;
    localparam int H_SYNC = 96;
    localparam int H_BACKPORCH = 48;

    localparam int H_TOTAL = H_ACTIVE + H_FRONTPORCH + H_SYNC + H_BACKPORCH;
    localparam int H_SYNC_START = H_ACTIVE + H_FRONTPORCH;
    localparam int H_SYNC_END = H_SYNC_START + H_SYNC;

    // Vertical, in lines
    localparam int V_ACTIVE = 480;
    localparam int V_FRONTPORCH = 11;
    localparam int V_SYNC = 2;
    localparam int V_BACKPORCH = 31;

    localparam int V_TOTAL = V_ACTIVE + V_FRONTPORCH + V_SYNC + V_BACKPORCH;
    localparam int V_SYNC_START = V_ACTIVE + V_FRONTPORCH;
    localparam int V_SYNC_END = V_SYNC_START + V_SYNC;

    typedef logic [11:0] raster_x_t;
    typedef logic [10:0] raster_y_t;

endpackage

`default_nettype wire

// File: vlog.f
rtl/video_timing_pkg.sv
rtl/vdp_pkg.sv
rtl/vga_timing.sv
rtl/host_regs.sv
rtl/layer_priority.sv
rtl/palette_ram.sv
rtl/blender.sv
rtl/vdp_top.sv
bench/vdp_tb.sv
